// ==== design/grad_lane.sv ====
module grad_lane (
    input  logic                               clk,
    input  logic                               reset,
    input  grad_types_pkg::pixel_beat_t        beat,
    input  logic [img_geom_pkg::LANE_W-1:0]    lane_id,
    output grad_types_pkg::lane_result_t       result
);

    import img_geom_pkg::*;
    import grad_types_pkg::*;

    logic             mine;
    logic             emit;
    logic [PIX_W-1:0] top_prev;
    logic [PIX_W-1:0] bottom_prev;

    // Only beats of this lane's rows move the window
    assign mine = beat.valid && (beat.lane == lane_id);

    // A top pixel at column c+1 completes the window of column c
    assign emit = mine && !beat.bottom && (beat.col != '0);

    always_ff @(posedge clk) begin
        if (mine) begin
            if (beat.bottom) begin
                bottom_prev <= beat.pixel;
            end else begin
                top_prev <= beat.pixel;
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= emit;
            // Zero extended before subtracting, so the 10-bit result is exact
            if (emit) begin
                result.row            <= beat.row;
                result.col            <= beat.col - 1'b1;
                result.grad.fields.gx <= DIFF_W'(beat.pixel) - DIFF_W'(top_prev);
                result.grad.fields.gy <= DIFF_W'(bottom_prev) - DIFF_W'(top_prev);
            end
        end
    end

endmodule

// ==== design/grad_types_pkg.sv ====
package grad_types_pkg;

    import img_geom_pkg::*;

    // Signed view of one gradient word, gx in the upper half
    typedef struct packed {
        logic signed [DIFF_W-1:0] gx;
        logic signed [DIFF_W-1:0] gy;
    } grad_fields_t;

    // Lanes fill the fields, the memory port sees the raw word
    typedef union packed {
        logic [2*DIFF_W-1:0] raw;
        grad_fields_t        fields;
    } grad_word_u;

    // One returned pixel with the tag of its read
    typedef struct packed {
        logic               valid;
        logic [LANE_W-1:0]  lane;
        // High for the pixel of row r+1
        logic               bottom;
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
        logic [PIX_W-1:0]   pixel;
    } pixel_beat_t;

    // Registered output of one lane
    typedef struct packed {
        logic               valid;
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
        grad_word_u         grad;
    } lane_result_t;

endpackage

// ==== design/grad_writer.sv ====
module grad_writer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  grad_types_pkg::lane_result_t         results [img_geom_pkg::NUM_LANES],
    input  logic                                 fetch_done,
    output logic                                 grad_wr,
    output logic [img_geom_pkg::ADDR_W-1:0]      grad_addr,
    output logic [2*img_geom_pkg::DIFF_W-1:0]    grad_do,
    output logic                                 done
);

    import img_geom_pkg::*;
    import grad_types_pkg::*;

    lane_result_t sel;
    // Cycles seen since fetch_done, the last result trails it by one
    logic [1:0]   drain_cnt;

    // Lane 0 wins, though only one lane is ever valid at a time
    always_comb begin
        sel = '0;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (results[k].valid) begin
                sel = results[k];
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= sel.valid;
        end
    end

    always_ff @(posedge clk) begin
        grad_addr <= ADDR_W'(sel.row) * ADDR_W'(IMG_WIDTH) + ADDR_W'(sel.col);
        grad_do   <= sel.grad.raw;
    end

    // done follows the final write by one cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            drain_cnt <= '0;
            done      <= 1'b0;
        end else if (fetch_done && !done) begin
            if (drain_cnt == 2'd1 && !sel.valid) begin
                done <= 1'b1;
            end else begin
                drain_cnt <= drain_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/image_gradient.sv ====
module image_gradient (
    input  logic                                 clk,
    input  logic                                 reset,
    output logic                                 img_rd,
    output logic [img_geom_pkg::ADDR_W-1:0]      img_addr,
    input  logic [img_geom_pkg::PIX_W-1:0]       img_di,
    output logic                                 grad_wr,
    output logic [img_geom_pkg::ADDR_W-1:0]      grad_addr,
    output logic [2*img_geom_pkg::DIFF_W-1:0]    grad_do,
    output logic                                 done
);

    import img_geom_pkg::*;
    import grad_types_pkg::*;

    pixel_beat_t  beat;
    logic         fetch_done;
    lane_result_t results [NUM_LANES];

    pixel_fetch u_pixel_fetch (
        .clk        (clk),
        .reset      (reset),
        .img_di     (img_di),
        .img_rd     (img_rd),
        .img_addr   (img_addr),
        .beat       (beat),
        .fetch_done (fetch_done)
    );

    // Every lane sees every beat and keeps the rows with row mod 4 == k
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        grad_lane u_grad_lane (
            .clk     (clk),
            .reset   (reset),
            .beat    (beat),
            .lane_id (LANE_W'(k)),
            .result  (results[k])
        );
    end

    grad_writer u_grad_writer (
        .clk        (clk),
        .reset      (reset),
        .results    (results),
        .fetch_done (fetch_done),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .done       (done)
    );

endmodule

// ==== design/img_geom_pkg.sv ====
package img_geom_pkg;

    // Image size in pixels
    localparam int IMG_WIDTH  = 256;
    localparam int IMG_HEIGHT = 256;

    // Pixel and memory address widths
    localparam int PIX_W  = 8;
    localparam int ADDR_W = 16;

    // Width of a row or column index
    localparam int COORD_W = 8;

    // Rows are dealt to the lanes by row mod NUM_LANES
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = 2;

    // One signed difference of two 8-bit pixels
    localparam int DIFF_W = 10;

endpackage

// ==== design/pixel_fetch.sv ====
module pixel_fetch (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [img_geom_pkg::PIX_W-1:0]    img_di,
    output logic                              img_rd,
    output logic [img_geom_pkg::ADDR_W-1:0]   img_addr,
    output grad_types_pkg::pixel_beat_t       beat,
    output logic                              fetch_done
);

    import img_geom_pkg::*;
    import grad_types_pkg::*;

    // Coordinates of the read currently on the port
    logic               rd_q;
    logic [COORD_W-1:0] row_q;
    logic [COORD_W-1:0] col_q;
    logic               bot_q;
    logic               last_read;

    // Tag of the read issued in the previous cycle
    logic               tag_valid;
    logic [LANE_W-1:0]  tag_lane;
    logic               tag_bottom;
    logic [COORD_W-1:0] tag_row;
    logic [COORD_W-1:0] tag_col;

    assign last_read = (row_q == COORD_W'(IMG_HEIGHT - 2)) &&
                       (col_q == COORD_W'(IMG_WIDTH - 1)) && bot_q;

    // Bottom reads hit row r+1 of the current pair
    assign img_rd   = rd_q;
    assign img_addr = ADDR_W'(row_q + COORD_W'(bot_q)) * ADDR_W'(IMG_WIDTH) +
                      ADDR_W'(col_q);

    // Read order: top then bottom of each column, columns left to right
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_q       <= 1'b0;
            row_q      <= '0;
            col_q      <= '0;
            bot_q      <= 1'b0;
            fetch_done <= 1'b0;
        end else if (!fetch_done) begin
            if (!rd_q) begin
                // First read of the image at address 0
                rd_q <= 1'b1;
            end else if (last_read) begin
                rd_q       <= 1'b0;
                fetch_done <= 1'b1;
            end else if (bot_q) begin
                bot_q <= 1'b0;
                if (col_q == COORD_W'(IMG_WIDTH - 1)) begin
                    col_q <= '0;
                    row_q <= row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end else begin
                bot_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= rd_q;
        end
    end

    always_ff @(posedge clk) begin
        tag_lane   <= row_q[LANE_W-1:0];
        tag_bottom <= bot_q;
        tag_row    <= row_q;
        tag_col    <= col_q;
    end

    // Pixel arrives one cycle after its read, join it with the tag
    always_comb begin
        beat.valid  = tag_valid;
        beat.lane   = tag_lane;
        beat.bottom = tag_bottom;
        beat.row    = tag_row;
        beat.col    = tag_col;
        beat.pixel  = img_di;
    end

endmodule

// ==== dv/image_gradient_sva.sv ====
module image_gradient_sva (
    input logic                              clk,
    input logic                              reset,
    input logic                              img_rd,
    input logic [img_geom_pkg::ADDR_W-1:0]   img_addr,
    input logic                              grad_wr,
    input logic                              done
);

    timeunit 1ns;
    timeprecision 100ps;

    import img_geom_pkg::*;

    // High while the read on the port is the bottom one of a column
    logic bottom_read;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bottom_read <= 1'b0;
        end else if (img_rd) begin
            bottom_read <= !bottom_read;
        end
    end

    a_rd_in_reset: assert property (@(posedge clk) !reset |-> !img_rd)
        else $error("img_rd high while reset is active");

    a_no_wr_after_done: assert property (@(posedge clk) disable iff (!reset) done |-> !grad_wr)
        else $error("grad_wr high while done is high");

    a_done_sticky: assert property (@(posedge clk) disable iff (!reset) done |=> done)
        else $error("done dropped before reset");

    a_first_addr: assert property (@(posedge clk) disable iff (!reset)
        (img_rd && !$past(img_rd)) |-> (img_addr == '0))
        else $error("first read of a pass not at address 0");

    // Bottom read is one row below, the next top read is one column right of the last top
    a_bottom_addr: assert property (@(posedge clk) disable iff (!reset)
        (img_rd && bottom_read) |-> (img_addr == ADDR_W'($past(img_addr) + IMG_WIDTH)))
        else $error("bottom read address out of order");

    a_top_addr: assert property (@(posedge clk) disable iff (!reset)
        (img_rd && !bottom_read && $past(img_rd)) |->
        (img_addr == ADDR_W'($past(img_addr) - (IMG_WIDTH - 1))))
        else $error("top read address out of order");

endmodule

bind image_gradient image_gradient_sva u_image_gradient_sva (
    .clk      (clk),
    .reset    (reset),
    .img_rd   (img_rd),
    .img_addr (img_addr),
    .grad_wr  (grad_wr),
    .done     (done)
);

// ==== dv/image_gradient_tb.sv ====
module image_gradient_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import img_geom_pkg::*;

    localparam int MEM_WORDS       = IMG_WIDTH * IMG_HEIGHT;
    localparam int EXPECTED_WRITES = 65025;
    localparam int MID_RUN_WRITES  = 20000;
    localparam int PASS_TIMEOUT    = 140000;
    localparam int SHORT_TIMEOUT   = 8;
    localparam int IDLE_CYCLES     = 16;
    localparam logic [31:0] LCG_SEED = 32'd43;
    localparam logic [DIFF_W-1:0] PLUS_255  = 10'h0FF;
    localparam logic [DIFF_W-1:0] MINUS_255 = 10'h301;
    localparam int EDGE_ROWS [3] = '{0, 126, 253};

    logic                  clk;
    logic                  reset;
    logic                  reset_req;
    logic                  img_rd;
    logic [ADDR_W-1:0]     img_addr;
    logic [PIX_W-1:0]      img_di = '0;
    logic                  grad_wr;
    logic [ADDR_W-1:0]     grad_addr;
    logic [2*DIFF_W-1:0]   grad_do;
    logic                  done;

    logic [PIX_W-1:0]      img_mem [MEM_WORDS];
    logic [31:0]           lcg_state;
    bit                    written [MEM_WORDS];
    logic [2*DIFF_W-1:0]   got_word [MEM_WORDS];
    int                    write_count;
    logic [ADDR_W-1:0]     last_addr;
    bit                    scoreboard_clean;

    tb_clock_gen u_clock_gen (
        .reset_req (reset_req),
        .clk       (clk),
        .reset     (reset)
    );

    image_gradient u_image_gradient (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    // Image memory with a synchronous read
    always @(posedge clk) begin
        if (img_rd) begin
            img_di <= img_mem[img_addr];
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Both differences of zero extended pixels, gx in the upper half
    function automatic logic [2*DIFF_W-1:0] expected_word(input int r, input int c);
        logic [DIFF_W-1:0] here;
        logic [DIFF_W-1:0] right;
        logic [DIFF_W-1:0] below;
        here  = DIFF_W'(img_mem[r * IMG_WIDTH + c]);
        right = DIFF_W'(img_mem[r * IMG_WIDTH + c + 1]);
        below = DIFF_W'(img_mem[(r + 1) * IMG_WIDTH + c]);
        return {right - here, below - here};
    endfunction

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic load_image();
        for (int a = 0; a < MEM_WORDS; a++) begin
            lcg_state  = lcg_next(lcg_state);
            img_mem[a] = lcg_state[31:24];
        end
        // Alternating 0 and 255 over two rows gives gradients of +255 and -255
        for (int i = 0; i < 3; i++) begin
            for (int c = 0; c < IMG_WIDTH; c++) begin
                img_mem[EDGE_ROWS[i] * IMG_WIDTH + c]       = c[0] ? 8'hFF : 8'h00;
                img_mem[(EDGE_ROWS[i] + 1) * IMG_WIDTH + c] = c[0] ? 8'h00 : 8'hFF;
            end
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (!reset) begin
                assert (!img_rd && !grad_wr && !done) else begin
                    $display("Fail outputs in reset: img_rd %h grad_wr %h done %h, expected 0",
                             img_rd, grad_wr, done);
                    stop_on_failure();
                end
            end
        end while (!reset && n < SHORT_TIMEOUT);
        assert (reset) else begin
            $display("Timed out waiting for reset release");
            stop_on_failure();
        end
    endtask

    task automatic wait_writes(input int target);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (write_count < target && n < PASS_TIMEOUT);
        assert (write_count >= target) else begin
            $display("Timed out waiting for %0d writes, only %0d seen", target, write_count);
            stop_on_failure();
        end
    endtask

    task automatic run_full_pass();
        int n;
        int addr;
        logic [2*DIFF_W-1:0] edge_word;
        wait_writes(EXPECTED_WRITES);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < SHORT_TIMEOUT);
        assert (done) else begin
            $display("done did not rise after the last write");
            stop_on_failure();
        end
        // Engine must stay idle with done held
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            assert (done && !img_rd) else begin
                $display("Fail after done: done %h img_rd %h", done, img_rd);
                stop_on_failure();
            end
        end
        @(posedge clk);
        assert (write_count == EXPECTED_WRITES) else begin
            $display("Expected %0d writes, saw %0d", EXPECTED_WRITES, write_count);
            stop_on_failure();
        end
        for (int i = 0; i < 3; i++) begin
            for (int c = 0; c < IMG_WIDTH - 1; c++) begin
                addr      = EDGE_ROWS[i] * IMG_WIDTH + c;
                edge_word = c[0] ? {MINUS_255, MINUS_255} : {PLUS_255, PLUS_255};
                assert (got_word[addr] == edge_word) else begin
                    $display("Fail grad_do at address %h: expected %h, got %h",
                             addr, edge_word, got_word[addr]);
                    stop_on_failure();
                end
            end
        end
    endtask

    task automatic restart_dut();
        int n;
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (reset && n < SHORT_TIMEOUT);
        assert (!reset) else begin
            $display("Timed out waiting for reset to assert");
            stop_on_failure();
        end
        // Fresh image while the engine is held in reset
        load_image();
        wait_reset_release();
    endtask

    always @(negedge clk) begin : compare_writes
        int row;
        int col;
        logic [2*DIFF_W-1:0] exp_word;
        if (!reset) begin
            if (!scoreboard_clean) begin
                for (int a = 0; a < MEM_WORDS; a++) begin
                    written[a]  = 1'b0;
                    got_word[a] = '0;
                end
                write_count      = 0;
                last_addr        = '0;
                scoreboard_clean = 1'b1;
            end
        end else begin
            scoreboard_clean = 1'b0;
            assert (!done || write_count == EXPECTED_WRITES) else begin
                $display("done went high after only %0d writes", write_count);
                stop_on_failure();
            end
            if (grad_wr) begin
                row = int'(grad_addr[ADDR_W-1:COORD_W]);
                col = int'(grad_addr[COORD_W-1:0]);
                assert (!done) else begin
                    $display("Write to address %h while done is high", grad_addr);
                    stop_on_failure();
                end
                assert (row < IMG_HEIGHT - 1 && col < IMG_WIDTH - 1) else begin
                    $display("Write to address %h in the last row or column", grad_addr);
                    stop_on_failure();
                end
                assert (!written[grad_addr]) else begin
                    $display("Address %h written twice", grad_addr);
                    stop_on_failure();
                end
                assert (write_count == 0 || grad_addr > last_addr) else begin
                    $display("Address %h follows %h out of order", grad_addr, last_addr);
                    stop_on_failure();
                end
                exp_word = expected_word(row, col);
                assert (grad_do == exp_word) else begin
                    $display("Fail grad_do at address %h: expected %h, got %h",
                             grad_addr, exp_word, grad_do);
                    stop_on_failure();
                end
                written[grad_addr]  = 1'b1;
                got_word[grad_addr] = grad_do;
                last_addr           = grad_addr;
                write_count++;
            end
        end
    end

    initial begin
        reset_req = 1'b0;
        lcg_state = LCG_SEED;
        load_image();
        wait_reset_release();
        run_full_pass();
        // Second pass is cut short by a reset, the third runs to the end
        restart_dut();
        wait_writes(MID_RUN_WRITES);
        restart_dut();
        run_full_pass();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
module tb_clock_gen (
    input  logic reset_req,
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0] hold_cnt;

    initial begin
        clk      = 1'b0;
        reset    = 1'b0;
        hold_cnt = 2'd3;
    end

    always #10 clk = ~clk;

    // Reset stays low over three rising edges and is released on the third
    always @(posedge clk) begin
        if (reset_req) begin
            reset    <= 1'b0;
            hold_cnt <= 2'd3;
        end else if (hold_cnt != 2'd0) begin
            hold_cnt <= hold_cnt - 2'd1;
            if (hold_cnt == 2'd1) begin
                reset <= 1'b1;
            end
        end
    end

endmodule

// ==== flist.f ====
design/img_geom_pkg.sv
design/grad_types_pkg.sv
design/pixel_fetch.sv
design/grad_lane.sv
design/grad_writer.sv
design/image_gradient.sv
dv/tb_clock_gen.sv
dv/image_gradient_sva.sv
dv/image_gradient_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module image_gradient_tb -f flist.f -o sim_image_gradient; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_image_gradient 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
